/* include/capture_vectors.svh */
`ifndef CAPTURE_VECTORS_SVH
`define CAPTURE_VECTORS_SVH

// one row per record
typedef struct packed {
	adc_capture_pkg::samp_mode_e samp_mode;
	adc_capture_pkg::pack_mode_e pack_mode;
	logic [3:0]                  divisor;
	logic [15:0]                 rec_length; // words
	logic [15:0]                 num_frames; // valid frames offered
} capture_vec_t;

localparam int NUM_VECTORS = 8;

localparam capture_vec_t CAPTURE_VECTORS [NUM_VECTORS] = '{
	// raw, every frame
	'{adc_capture_pkg::SAMP_PICK, adc_capture_pkg::PACK_RAW, 4'd0, 16'd16, 16'd16},
	// every third frame, a few spare frames past the end
	'{adc_capture_pkg::SAMP_PICK, adc_capture_pkg::PACK_RAW, 4'd2, 16'd10, 16'd33},
	// sums of four
	'{adc_capture_pkg::SAMP_SUM, adc_capture_pkg::PACK_RAW, 4'd3, 16'd8, 16'd36},
	// packed, four frames to three words
	'{adc_capture_pkg::SAMP_PICK, adc_capture_pkg::PACK_12, 4'd0, 16'd12, 16'd16},
	// packed pair sums, truncated to 12 bits
	'{adc_capture_pkg::SAMP_SUM, adc_capture_pkg::PACK_12, 4'd1, 16'd9, 16'd24},
	// zero length record
	'{adc_capture_pkg::SAMP_PICK, adc_capture_pkg::PACK_RAW, 4'd0, 16'd0, 16'd4},
	// longest group
	'{adc_capture_pkg::SAMP_SUM, adc_capture_pkg::PACK_12, 4'd15, 16'd3, 16'd64},
	// record ends inside a packed group
	'{adc_capture_pkg::SAMP_PICK, adc_capture_pkg::PACK_12, 4'd2, 16'd5, 16'd24}
};

`endif

/* dv/tb_adc_capture.sv */
module tb_adc_capture;

	logic adc_clkinp;
	logic reset;
	adc_capture_pkg::adc_frame_t frame;
	logic frame_valid;
	adc_capture_pkg::capture_cfg_t cfg;
	logic [15:0] rec_length;
	logic trig;
	logic state_reset;
	logic trig_ack;
	adc_capture_pkg::mem_wr_t mem_wr;
	logic irq;

	`include "capture_vectors.svh"

	localparam int WAIT_LIMIT = 2000; // cycles per wait

	int errors;
	int checks;
	int wr_count; // writes seen in the current record
	logic [127:0] exp_q [$];

	// reference model state
	int m_cnt;
	adc_capture_pkg::lane_frame_t m_acc;
	int m_phase;
	logic [383:0] m_stream; // four packed frames, low bits first

	adc_capture_top #(
		.ADDR_W (15)
	) DUT (
		.adc_clkinp  (adc_clkinp),
		.reset       (reset),
		.frame       (frame),
		.frame_valid (frame_valid),
		.cfg         (cfg),
		.rec_length  (rec_length),
		.trig        (trig),
		.state_reset (state_reset),
		.trig_ack    (trig_ack),
		.mem_wr      (mem_wr),
		.irq         (irq)
	);

	always #20 adc_clkinp = ~adc_clkinp;

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("MISMATCH at %0t: %s = %h, expected %h", $time, name, actual, expected);
		end
	endtask

	// write monitor, wren is a one-cycle pulse so the falling edge sees it once
	always @(negedge adc_clkinp)
	begin
		if (!reset && mem_wr.wren === 1'b1)
		begin
			if (exp_q.size() == 0)
			begin
				errors++;
				$display("Unexpected memory write at %0t to address %0d, no word expected",
					$time, mem_wr.addr);
			end
			else
			begin
				check_value("mem_wr.addr", mem_wr.addr, wr_count);
				check_value("mem_wr.data", mem_wr.data, exp_q.pop_front());
			end
			wr_count++;
		end
	end

	function automatic adc_capture_pkg::adc_frame_t random_frame();
		adc_capture_pkg::adc_frame_t f;
		for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
			f.ch[i] = $urandom_range(4095);
		return f;
	endfunction

	// decimate one valid frame, then format it into expected words
	task automatic model_frame(input adc_capture_pkg::adc_frame_t f, input capture_vec_t v);
		adc_capture_pkg::lane_frame_t ext;
		adc_capture_pkg::lane_frame_t res;
		logic [95:0] pk;
		for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
			ext.lane[i] = {4'd0, f.ch[i]};
		if (m_cnt < v.divisor)
		begin
			for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
				m_acc.lane[i] = m_acc.lane[i] + ext.lane[i]; // 16-bit wrap
			m_cnt++;
		end
		else
		begin
			for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
				res.lane[i] = (v.samp_mode == adc_capture_pkg::SAMP_SUM) ?
					m_acc.lane[i] + ext.lane[i] : ext.lane[i];
			m_acc = '0;
			m_cnt = 0;
			if (v.pack_mode == adc_capture_pkg::PACK_RAW)
				exp_q.push_back(res);
			else
			begin
				for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
					pk[i*12 +: 12] = res.lane[i][11:0];
				m_stream[m_phase*96 +: 96] = pk;
				if (m_phase > 0) // a word is complete once enough bits are in
					exp_q.push_back(m_stream[(m_phase-1)*128 +: 128]);
				m_phase = (m_phase + 1) % 4;
			end
		end
	endtask

	task automatic wait_for_ack();
		int n;
		n = 0;
		while (trig_ack !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge adc_clkinp);
			n++;
		end
		if (trig_ack !== 1'b1)
		begin
			errors++;
			$display("Timeout at %0t: trig_ack never rose after trig", $time);
		end
	endtask

	task automatic wait_for_irq();
		int n;
		n = 0;
		while (irq !== 1'b1 && n < WAIT_LIMIT)
		begin
			@(negedge adc_clkinp);
			n++;
		end
		if (irq !== 1'b1)
		begin
			errors++;
			$display("Timeout at %0t: irq never rose at the end of the record", $time);
		end
	endtask

	task automatic run_record(input int idx, input capture_vec_t v);
		int sent;
		int err_start;
		err_start = errors;
		exp_q.delete();
		wr_count = 0;
		m_cnt = 0;
		m_acc = '0;
		m_phase = 0;
		m_stream = '0;
		cfg = '{samp_mode: v.samp_mode, pack_mode: v.pack_mode, divisor: v.divisor};
		rec_length = v.rec_length;
		@(negedge adc_clkinp);
		trig = 1'b1;
		wait_for_ack();
		trig = 1'b0;
		sent = 0;
		while (sent < v.num_frames) // random gaps in frame_valid
		begin
			frame = random_frame();
			frame_valid = ($urandom_range(3) != 0);
			if (frame_valid)
			begin
				model_frame(frame, v);
				sent++;
			end
			@(negedge adc_clkinp);
		end
		frame_valid = 1'b0;
		wait_for_irq();
		check_value("write count", wr_count, v.rec_length);
		check_value("trig_ack", trig_ack, 1'b0);
		// trig while done must be ignored
		trig = 1'b1;
		@(negedge adc_clkinp);
		trig = 1'b0;
		repeat (4) @(negedge adc_clkinp);
		check_value("trig_ack", trig_ack, 1'b0);
		check_value("irq", irq, 1'b1);
		check_value("write count", wr_count, v.rec_length);
		state_reset = 1'b1;
		@(negedge adc_clkinp);
		state_reset = 1'b0;
		check_value("irq", irq, 1'b0);
		$display("test %0d: samp %0d pack %0d div %0d len %0d writes %0d errors %0d", idx,
			v.samp_mode, v.pack_mode, v.divisor, v.rec_length, wr_count, errors - err_start);
	endtask

	initial
	begin
		errors = 0;
		checks = 0;
		wr_count = 0;
		void'($urandom(32'hbc9b));
		adc_clkinp = 1'b0;
		reset = 1'b1;
		frame = '0;
		frame_valid = 1'b0;
		cfg = '0;
		rec_length = '0;
		trig = 1'b0;
		state_reset = 1'b0;
		repeat (8) @(negedge adc_clkinp);
		reset = 1'b0;
		check_value("trig_ack", trig_ack, 1'b0);
		check_value("irq", irq, 1'b0);
		check_value("mem_wr.wren", mem_wr.wren, 1'b0);
		repeat (6) // frames without trig write nothing
		begin
			frame = random_frame();
			frame_valid = 1'b1;
			@(negedge adc_clkinp);
		end
		frame_valid = 1'b0;
		check_value("write count", wr_count, 0);
		$display("idle: errors %0d", errors);
		for (int t = 0; t < NUM_VECTORS; t++)
			run_record(t, CAPTURE_VECTORS[t]);
		$display("tests %0d, checks %0d, errors %0d", NUM_VECTORS + 1, checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* src/adc_capture_pkg.sv */
package adc_capture_pkg;

	localparam int NUM_CH = 8;
	localparam int SAMPLE_W = 12;
	localparam int LANE_W = 16; // one channel in a sum or raw word
	localparam int WORD_W = 128;
	localparam int ADDR_MAX_W = 15; // widest record address

	// one sample per channel, channel 0 in the low bits
	typedef struct packed {
		logic [NUM_CH-1:0][SAMPLE_W-1:0] ch;
	} adc_frame_t;

	// same channel order, widened to 16-bit lanes
	typedef struct packed {
		logic [NUM_CH-1:0][LANE_W-1:0] lane;
	} lane_frame_t;

	typedef enum logic {
		SAMP_PICK, // keep the last frame of each group
		SAMP_SUM   // per-channel sum over the group
	} samp_mode_e;

	typedef enum logic {
		PACK_RAW, // one lane frame per word
		PACK_12   // four frames in three words
	} pack_mode_e;

	typedef struct packed {
		samp_mode_e samp_mode;
		pack_mode_e pack_mode;
		logic [3:0] divisor; // group length minus one
	} capture_cfg_t;

	// record memory write port
	typedef struct packed {
		logic                  wren;
		logic [ADDR_MAX_W-1:0] addr;
		logic [WORD_W-1:0]     data;
	} mem_wr_t;

endpackage

/* src/adc_capture_top.sv */
module adc_capture_top #(
	parameter int ADDR_W = 15 // record depth, at most ADDR_MAX_W
) (
	input  logic                          adc_clkinp,
	input  logic                          reset,
	input  adc_capture_pkg::adc_frame_t   frame,
	input  logic                          frame_valid,
	input  adc_capture_pkg::capture_cfg_t cfg,
	input  logic [15:0]                   rec_length,
	input  logic                          trig,
	input  logic                          state_reset,
	output logic                          trig_ack,
	output adc_capture_pkg::mem_wr_t      mem_wr,
	output logic                          irq
);

	logic capturing; // gates the whole chain
	adc_capture_pkg::lane_frame_t dec_frame;
	logic dec_valid;
	logic [adc_capture_pkg::WORD_W-1:0] word;
	logic word_valid;

	sample_decimator u_decimator (
		.adc_clkinp  (adc_clkinp),
		.reset       (reset),
		.capturing   (capturing),
		.samp_mode   (cfg.samp_mode),
		.divisor     (cfg.divisor),
		.frame       (frame),
		.frame_valid (frame_valid),
		.dec_frame   (dec_frame),
		.dec_valid   (dec_valid)
	);

	sample_packer u_packer (
		.adc_clkinp (adc_clkinp),
		.reset      (reset),
		.capturing  (capturing),
		.pack_mode  (cfg.pack_mode),
		.dec_frame  (dec_frame),
		.dec_valid  (dec_valid),
		.word       (word),
		.word_valid (word_valid)
	);

	capture_ctrl #(
		.ADDR_W (ADDR_W)
	) u_ctrl (
		.adc_clkinp  (adc_clkinp),
		.reset       (reset),
		.state_reset (state_reset),
		.trig        (trig),
		.rec_length  (rec_length),
		.word        (word),
		.word_valid  (word_valid),
		.capturing   (capturing),
		.trig_ack    (trig_ack),
		.mem_wr      (mem_wr),
		.irq         (irq)
	);

endmodule

/* src/capture_ctrl.sv */
module capture_ctrl #(
	parameter int ADDR_W = 15
) (
	input  logic                               adc_clkinp,
	input  logic                               reset,
	input  logic                               state_reset,
	input  logic                               trig,
	input  logic [15:0]                        rec_length,
	input  logic [adc_capture_pkg::WORD_W-1:0] word,
	input  logic                               word_valid,
	output logic                               capturing,
	output logic                               trig_ack,
	output adc_capture_pkg::mem_wr_t           mem_wr,
	output logic                               irq
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_CAPT,
		ST_DONE
	} state_t;

	state_t state;
	logic [ADDR_W:0] addr_cnt; // extra top bit flags overflow
	logic rec_end;
	logic wr_accept;
	logic [adc_capture_pkg::ADDR_MAX_W-1:0] addr_ext;
	logic wr_en;
	logic [adc_capture_pkg::ADDR_MAX_W-1:0] wr_addr;
	logic [adc_capture_pkg::WORD_W-1:0] wr_data;

	assign capturing = (state == ST_CAPT);
	assign rec_end = addr_cnt[ADDR_W] || (addr_cnt >= rec_length);
	assign wr_accept = capturing && word_valid && !rec_end; // late words are dropped

	always_comb
	begin
		addr_ext = '0;
		addr_ext[ADDR_W-1:0] = addr_cnt[ADDR_W-1:0];
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || state_reset)
		begin
			state <= ST_IDLE;
			trig_ack <= 1'b0;
			irq <= 1'b0;
			addr_cnt <= '0;
		end
		else
		begin
			case (state)
				ST_IDLE:
					if (trig)
					begin
						state <= ST_CAPT;
						trig_ack <= 1'b1;
						addr_cnt <= '0;
					end
				ST_CAPT:
					if (rec_end)
					begin
						state <= ST_DONE;
						trig_ack <= 1'b0;
						irq <= 1'b1; // held until state_reset
					end
					else if (wr_accept)
						addr_cnt <= addr_cnt + 1'b1;
				default: ; // done, trig ignored
			endcase
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || state_reset)
			wr_en <= 1'b0;
		else
			wr_en <= wr_accept;
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (wr_accept)
		begin
			wr_addr <= addr_ext;
			wr_data <= word;
		end
	end

	assign mem_wr = '{wren: wr_en, addr: wr_addr, data: wr_data};

	// every write happens while capturing and lands inside the record
	wren_in_capture: assert property (@(posedge adc_clkinp) disable iff (reset || state_reset)
		mem_wr.wren |-> capturing && (mem_wr.addr < rec_length))
		else $error("memory write outside of a capture or past the record length");

endmodule

/* src/sample_decimator.sv */
module sample_decimator (
	input  logic                         adc_clkinp,
	input  logic                         reset,
	input  logic                         capturing,
	input  adc_capture_pkg::samp_mode_e  samp_mode,
	input  logic [3:0]                   divisor,
	input  adc_capture_pkg::adc_frame_t  frame,
	input  logic                         frame_valid,
	output adc_capture_pkg::lane_frame_t dec_frame,
	output logic                         dec_valid
);

	logic [3:0] grp_cnt; // index of the next frame within its group
	logic grp_last;
	adc_capture_pkg::lane_frame_t ext_frame; // input zero-extended to lanes
	adc_capture_pkg::lane_frame_t sum_frame;
	adc_capture_pkg::lane_frame_t acc; // running sum of the open group

	assign grp_last = (grp_cnt == divisor);

	always_comb
	begin
		for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
		begin
			ext_frame.lane[i] = '0;
			ext_frame.lane[i][adc_capture_pkg::SAMPLE_W-1:0] = frame.ch[i];
			sum_frame.lane[i] = acc.lane[i] + ext_frame.lane[i]; // wraps at 16 bits
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || !capturing)
		begin
			grp_cnt <= '0;
			dec_valid <= 1'b0;
		end
		else
		begin
			dec_valid <= frame_valid && grp_last;
			if (frame_valid)
			begin
				if (grp_last)
					grp_cnt <= '0;
				else
					grp_cnt <= grp_cnt + 4'd1;
			end
		end
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (!capturing)
			acc <= '0;
		else if (frame_valid)
		begin
			if (grp_last)
			begin
				acc <= '0; // next group starts from zero
				if (samp_mode == adc_capture_pkg::SAMP_SUM)
					dec_frame <= sum_frame;
				else
					dec_frame <= ext_frame; // pick keeps the closing frame
			end
			else
				acc <= sum_frame;
		end
	end

	// a decimated frame only comes from a frame taken in during capture
	dec_valid_from_capture: assert property (@(posedge adc_clkinp) disable iff (reset)
		dec_valid |-> $past(capturing))
		else $error("dec_valid raised without capturing in the previous cycle");

endmodule

/* src/sample_packer.sv */
module sample_packer (
	input  logic                                   adc_clkinp,
	input  logic                                   reset,
	input  logic                                   capturing,
	input  adc_capture_pkg::pack_mode_e            pack_mode,
	input  adc_capture_pkg::lane_frame_t           dec_frame,
	input  logic                                   dec_valid,
	output logic [adc_capture_pkg::WORD_W-1:0]     word,
	output logic                                   word_valid
);

	logic [1:0] phase; // frame slot within a group of four
	logic packed_mode;
	logic [adc_capture_pkg::NUM_CH*adc_capture_pkg::SAMPLE_W-1:0] pk_frame;
	logic [adc_capture_pkg::NUM_CH*adc_capture_pkg::SAMPLE_W-1:0] carry; // bits not yet written

	assign packed_mode = (pack_mode == adc_capture_pkg::PACK_12);

	// low 12 bits of each lane, channel 0 first
	always_comb
	begin
		for (int i = 0; i < adc_capture_pkg::NUM_CH; i++)
			pk_frame[i*adc_capture_pkg::SAMPLE_W +: adc_capture_pkg::SAMPLE_W] =
				dec_frame.lane[i][adc_capture_pkg::SAMPLE_W-1:0];
	end

	always_ff @(posedge adc_clkinp)
	begin
		if (reset || !capturing)
		begin
			phase <= 2'd0;
			word_valid <= 1'b0;
		end
		else
		begin
			word_valid <= dec_valid && (!packed_mode || phase != 2'd0);
			if (dec_valid && packed_mode)
				phase <= phase + 2'd1;
		end
	end

	// 384-bit stream of four frames, emitted low bits first
	always_ff @(posedge adc_clkinp)
	begin
		if (dec_valid)
		begin
			if (!packed_mode)
				word <= dec_frame;
			else
			begin
				case (phase)
					2'd0:
						carry <= pk_frame; // held until the next frame
					2'd1:
					begin
						word <= {pk_frame[31:0], carry};
						carry <= {32'd0, pk_frame[95:32]};
					end
					2'd2:
					begin
						word <= {pk_frame[63:0], carry[63:0]};
						carry <= {64'd0, pk_frame[95:64]};
					end
					default:
						word <= {pk_frame, carry[31:0]}; // closes the three-word group
				endcase
			end
		end
	end

	// first frame of a packed group never yields a word
	no_word_on_phase0: assert property (@(posedge adc_clkinp) disable iff (reset)
		packed_mode && word_valid |-> phase != 2'd1)
		else $error("word_valid after the first frame of a packed group");

endmodule

/* vlog.f */
+incdir+include
src/adc_capture_pkg.sv
src/sample_decimator.sv
src/sample_packer.sv
src/capture_ctrl.sv
src/adc_capture_top.sv
dv/tb_adc_capture.sv
